// File: Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = vga_fb_tb
FILELIST = tb.f
OBJ_DIR  = obj_dir
LOG      = run.log

.PHONY: all compile run clean

all: run

compile:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "ERRORS FOUND" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "NO ERRORS" $(LOG) || (echo "simulation ended without a result"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: rtl/fb_pkg.sv
// frame-buffer word type and SRAM address constants
// word FIFO sizing
package fb_pkg;

    localparam int WORD_W = 32;    // one-bit pixels per word, msb first

    typedef logic [WORD_W-1:0] fb_word_t;

    localparam int ADDR_W = 32;
    localparam logic [ADDR_W-1:0] FB_BASE = '0;

    // frame-buffer geometry follows the active area
    localparam int WORDS_PER_LINE = vga_timing_pkg::H_ACTIVE / WORD_W;
    localparam int FRAME_WORDS    = WORDS_PER_LINE * vga_timing_pkg::V_ACTIVE;

    // word FIFO between fetcher and serializer
    localparam int FIFO_DEPTH = 4;
    localparam int FIFO_PTR_W = 2;

endpackage

// File: rtl/pixel_serializer.sv
// pixel shift register fed from the word FIFO, one pixel per clock
// syncs and display enable registered to line up with the pixel
`timescale 1ns/10ps

module pixel_serializer import vga_timing_pkg::*, fb_pkg::*; (
    input  logic               clk,
    input  logic               nrst,
    input  logic [H_CNT_W-1:0] h_count,
    input  logic               active,
    input  logic               hsync_in,
    input  logic               vsync_in,
    word_fifo_if.consumer      fifo,
    output logic               hsync,
    output logic               vsync,
    output logic               de,
    output logic               pixel,
    output logic               underrun
);

    fb_word_t shift_word;
    logic     armed;   // set at the first vsync, first frame stays blank
    logic     show;
    logic     load;

    assign show = active && armed;
    assign load = show && (h_count[$clog2(WORD_W)-1:0] == '0);   // start of a word group

    assign fifo.pop = load && !fifo.empty;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            armed    <= 1'b0;
            hsync    <= 1'b1;
            vsync    <= 1'b1;
            de       <= 1'b0;
            pixel    <= 1'b0;
            underrun <= 1'b0;
        end else begin
            if (!vsync_in) armed <= 1'b1;
            hsync <= hsync_in;
            vsync <= vsync_in;
            de    <= show;
            if (load) begin
                pixel <= fifo.empty ? 1'b0 : fifo.rdata[WORD_W-1];   // msb goes out first
            end else if (show) begin
                pixel <= shift_word[WORD_W-1];
            end else begin
                pixel <= 1'b0;
            end
            if (load && fifo.empty) underrun <= 1'b1;   // sticky
        end
    end

    always_ff @(posedge clk) begin
        if (load) shift_word <= fifo.empty ? '0 : (fifo.rdata << 1);
        else      shift_word <= shift_word << 1;
    end

endmodule

// File: rtl/sram_fetch_ctrl.sv
// frame-buffer fetcher that walks SRAM word addresses once per frame
// and pushes the returned words into the word FIFO
`timescale 1ns/10ps

module sram_fetch_ctrl import fb_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    input  logic              frame_start,
    output logic              sram_read,
    output logic [ADDR_W-1:0] sram_address,
    input  fb_word_t          sram_data,
    word_fifo_if.producer     fifo
);

    typedef enum logic [1:0] {
        IDLE,
        REQUEST,
        LOAD
    } state_t;

    state_t                           state;
    logic [ADDR_W-1:0]                addr;
    logic [$clog2(FRAME_WORDS+1)-1:0] req_cnt;   // words requested this frame
    logic                             more_words;

    assign more_words = (req_cnt < FRAME_WORDS);

    // one read in flight at most, stalls while the FIFO is full
    assign sram_read = (state == REQUEST) && more_words && !fifo.full && !frame_start;
    assign sram_address = addr;

    // sram_data is valid in the cycle after the read strobe
    assign fifo.push  = (state == LOAD);
    assign fifo.wdata = sram_data;
    assign fifo.flush = frame_start;   // drop leftovers of the last frame

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state   <= IDLE;
            addr    <= FB_BASE;
            req_cnt <= '0;
        end else if (frame_start) begin
            state   <= REQUEST;
            addr    <= FB_BASE;
            req_cnt <= '0;
        end else begin
            case (state)
                IDLE: begin
                    if (more_words) state <= REQUEST;   // walk starts at reset release
                end
                REQUEST: begin
                    if (sram_read) begin
                        state   <= LOAD;
                        req_cnt <= req_cnt + 1'b1;
                    end else if (!more_words) begin
                        state <= IDLE;
                    end
                end
                LOAD: begin
                    addr  <= addr + 1'b1;
                    state <= REQUEST;
                end
                default: state <= IDLE;
            endcase
        end
    end

    a_read_gap : assert property (@(posedge clk) disable iff (!nrst)
        sram_read |=> !sram_read);

endmodule

// File: rtl/vga_fb_top.sv
// monochrome VGA frame-buffer reader top level
// timing generator, SRAM fetcher, word FIFO and pixel serializer
`timescale 1ns/10ps

module vga_fb_top import vga_timing_pkg::*, fb_pkg::*; (
    input  logic              clk,
    input  logic              nrst,
    output logic              sram_read,
    output logic [ADDR_W-1:0] sram_address,
    input  fb_word_t          sram_data,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic              pixel,
    output logic              underrun
);

    logic [H_CNT_W-1:0] h_count;
    logic               hsync_raw;   // combinational, one cycle ahead of the pins
    logic               vsync_raw;
    logic               active;
    logic               frame_start;

    word_fifo_if fifo_bus ();

    // whole-frame fetch has no use for v_count or line_start
    vga_timing_gen timing_inst (
        .clk         (clk),
        .nrst        (nrst),
        .h_count     (h_count),
        .v_count     (),
        .hsync       (hsync_raw),
        .vsync       (vsync_raw),
        .active      (active),
        .frame_start (frame_start),
        .line_start  ()
    );

    sram_fetch_ctrl fetch_inst (.clk(clk), .nrst(nrst), .frame_start(frame_start),
        .sram_read(sram_read), .sram_address(sram_address), .sram_data(sram_data),
        .fifo(fifo_bus.producer));

    word_fifo fifo_inst (.clk(clk), .nrst(nrst), .fifo(fifo_bus.buffer));

    pixel_serializer serial_inst (.clk(clk), .nrst(nrst), .h_count(h_count),
        .active(active), .hsync_in(hsync_raw), .vsync_in(vsync_raw),
        .fifo(fifo_bus.consumer), .hsync(hsync), .vsync(vsync), .de(de),
        .pixel(pixel), .underrun(underrun));

endmodule

// File: rtl/vga_timing_gen.sv
// free-running VGA h/v counters with sync, active area decode
// and frame/line start pulses
`timescale 1ns/10ps

module vga_timing_gen import vga_timing_pkg::*; (
    input  logic               clk,
    input  logic               nrst,
    output logic [H_CNT_W-1:0] h_count,
    output logic [V_CNT_W-1:0] v_count,
    output logic               hsync,
    output logic               vsync,
    output logic               active,
    output logic               frame_start,
    output logic               line_start
);

    logic line_end;

    assign line_end = (h_count == H_TOTAL - 1);

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            h_count <= '0;
            v_count <= '0;
        end else begin
            if (line_end) begin
                h_count <= '0;
                if (v_count == V_TOTAL - 1) begin
                    v_count <= '0;
                end else begin
                    v_count <= v_count + 1'b1;
                end
            end else begin
                h_count <= h_count + 1'b1;
            end
        end
    end

    // both syncs active low
    assign hsync = !((h_count >= H_ACTIVE + H_FRONT) &&
                     (h_count <  H_ACTIVE + H_FRONT + H_SYNC));
    assign vsync = !((v_count >= V_ACTIVE + V_FRONT) &&
                     (v_count <  V_ACTIVE + V_FRONT + V_SYNC));

    assign active = (h_count < H_ACTIVE) && (v_count < V_ACTIVE);

    // first front-porch line, fetcher restarts here
    assign frame_start = (v_count == V_ACTIVE) && (h_count == 0);
    assign line_start  = (v_count <  V_ACTIVE) && (h_count == 0);

    a_h_range : assert property (@(posedge clk) disable iff (!nrst)
        h_count < H_TOTAL);

endmodule

// File: rtl/vga_timing_pkg.sv
// horizontal and vertical VGA timing constants
// counter widths for the timing generator
package vga_timing_pkg;

    // horizontal, in pixel clocks
    localparam int H_ACTIVE = 64;
    localparam int H_FRONT  = 4;
    localparam int H_SYNC   = 8;
    localparam int H_BACK   = 4;
    localparam int H_TOTAL  = 80;

    // vertical, in lines
    localparam int V_ACTIVE = 4;
    localparam int V_FRONT  = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BACK   = 1;
    localparam int V_TOTAL  = 8;

    localparam int H_CNT_W  = 7;   // covers 0..H_TOTAL-1
    localparam int V_CNT_W  = 3;   // covers 0..V_TOTAL-1

endpackage

// File: rtl/word_fifo.sv
// circular word buffer with full/empty status and one-cycle flush
`timescale 1ns/10ps

module word_fifo import fb_pkg::*; (
    input  logic        clk,
    input  logic        nrst,
    word_fifo_if.buffer fifo
);

    fb_word_t              mem [FIFO_DEPTH];
    logic [FIFO_PTR_W-1:0] wr_ptr;
    logic [FIFO_PTR_W-1:0] rd_ptr;
    logic [FIFO_PTR_W:0]   count;
    logic                  wr_en;
    logic                  rd_en;

    assign wr_en = fifo.push && !fifo.full;
    assign rd_en = fifo.pop && !fifo.empty;

    assign fifo.full  = (count == FIFO_DEPTH);
    assign fifo.empty = (count == 0);
    assign fifo.rdata = mem[rd_ptr];   // head word

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else if (fifo.flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_en) wr_ptr <= wr_ptr + 1'b1;   // wraps at depth
            if (rd_en) rd_ptr <= rd_ptr + 1'b1;
            case ({wr_en, rd_en})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) mem[wr_ptr] <= fifo.wdata;
    end

    // producer must respect full, consumer must respect empty
    a_no_overflow : assert property (@(posedge clk) disable iff (!nrst)
        !(fifo.push && fifo.full));

    a_no_underflow : assert property (@(posedge clk) disable iff (!nrst)
        !(fifo.pop && fifo.empty));

endmodule

// File: rtl/word_fifo_if.sv
// word FIFO connection between fetcher, buffer and serializer
// plain strobes, no handshake
`timescale 1ns/10ps

interface word_fifo_if import fb_pkg::*; ();

    logic     push;    // write wdata this cycle
    fb_word_t wdata;
    logic     full;
    logic     empty;
    logic     pop;     // drop head word this cycle
    fb_word_t rdata;   // head word, always valid when not empty
    logic     flush;   // clears everything, wins over push/pop

    modport producer (output push, wdata, flush, input full);

    modport buffer (input push, wdata, pop, flush, output full, empty, rdata);

    modport consumer (output pop, input rdata, empty);

endinterface

// File: tb.f
rtl/vga_timing_pkg.sv
rtl/fb_pkg.sv
rtl/word_fifo_if.sv
rtl/vga_timing_gen.sv
rtl/sram_fetch_ctrl.sv
rtl/word_fifo.sv
rtl/pixel_serializer.sv
rtl/vga_fb_top.sv
test/sram_model.sv
test/vga_fb_tb.sv

// File: test/sram_model.sv
// behavioural SRAM with one-cycle read latency
// fill patterns selected by code: 0 zero, 1 ones, 2 address hash, 3 random
`timescale 1ns/10ps

module sram_model import fb_pkg::*; (
    input  logic              clk,
    input  logic              read,
    input  logic [ADDR_W-1:0] address,
    output fb_word_t          data
);

    localparam int MEM_WORDS = 256;

    fb_word_t mem [MEM_WORDS];

    initial data = '0;

    // data shows up the cycle after the strobe
    always @(posedge clk) begin
        if (read) data <= mem[address[7:0]];
    end

    task automatic fill(input int pattern);
        logic [31:0] a;
        for (int i = 0; i < MEM_WORDS; i++) begin
            a = i;
            case (pattern)
                0:       mem[i] = '0;
                1:       mem[i] = '1;
                2:       mem[i] = (a * 32'h9e37_79b1) ^ {a[15:0], ~a[15:0]};   // spreads all bits
                default: mem[i] = $urandom();
            endcase
        end
    endtask

endmodule

// File: test/vga_fb_tb.sv
// testbench for the VGA frame-buffer reader
// SRAM pattern table loop with pixel, sync, display area and underrun checks
`timescale 1ns/10ps

module vga_fb_tb import vga_timing_pkg::*, fb_pkg::*; ();

    localparam int PAT_ZERO = 0;
    localparam int PAT_ONE  = 1;
    localparam int PAT_HASH = 2;
    localparam int PAT_RAND = 3;
    localparam int NUM_ROWS = 4;
    localparam int FRAME_TIMEOUT = 2 * H_TOTAL * V_TOTAL;

    typedef struct packed {
        int pattern;
        int frames;      // checked frames after the blank first one
        int exp_hsync;
        int exp_de;
    } row_t;

    logic              clk = 1'b0;
    logic              nrst;
    logic              sram_read;
    logic [ADDR_W-1:0] sram_address;
    fb_word_t          sram_data;
    logic              hsync, vsync, de, pixel, underrun;

    row_t rows [NUM_ROWS];
    logic prev_hsync, prev_vsync, prev_de;
    int   hs_low, vs_low, hs_falls, de_cnt, rd_cnt, x, y;

    always #4 clk = ~clk;

    vga_fb_top vga_fb_top_inst (.clk(clk), .nrst(nrst), .sram_read(sram_read),
        .sram_address(sram_address), .sram_data(sram_data), .hsync(hsync), .vsync(vsync),
        .de(de), .pixel(pixel), .underrun(underrun));

    sram_model sram_inst (.clk(clk), .read(sram_read), .address(sram_address), .data(sram_data));

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s expected 0x%0h actual 0x%0h", name, expected, actual);
            $display("ERRORS FOUND");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // samples at the falling edge until vsync falls, checking every cycle
    task automatic watch_frame();
        int          cycles;
        bit          done;
        logic [31:0] addr;
        fb_word_t    word;
        cycles   = 0;
        done     = 1'b0;
        hs_falls = 0;
        de_cnt   = 0;
        rd_cnt   = 0;
        while (!done) begin
            @(negedge clk);
            cycles++;
            if (cycles > FRAME_TIMEOUT) begin
                $display("timeout waiting for vsync");
                $display("ERRORS FOUND");
                $fatal(1, "no vsync edge within %0d clocks", FRAME_TIMEOUT);
            end
            check_value("underrun", 0, underrun);
            if (sram_read) begin
                // reads stay inside the frame buffer
                check_value("sram_address_in_frame", 1, sram_address < FB_BASE + FRAME_WORDS);
                rd_cnt++;
            end
            if (de) check_value("vsync", 1, vsync);   // no display during vertical sync
            if (!hsync) begin
                if (prev_hsync) hs_falls++;
                hs_low++;
            end else if (!prev_hsync) begin
                check_value("hsync_low_clocks", H_SYNC, hs_low);
                hs_low = 0;
            end
            if (!vsync) begin
                if (prev_vsync) begin
                    done = 1'b1;
                    x = 0;
                    y = 0;
                end
                vs_low++;
            end else if (!prev_vsync) begin
                check_value("vsync_low_clocks", V_SYNC * H_TOTAL, vs_low);
                vs_low = 0;
            end
            if (de) begin
                addr = FB_BASE + y * WORDS_PER_LINE + x / WORD_W;
                word = sram_inst.mem[addr[7:0]];
                check_value("pixel", word[WORD_W - 1 - x % WORD_W], pixel);
                x++;
                de_cnt++;
            end else if (prev_de) begin
                y++;   // end of an active line
                x = 0;
            end
            prev_hsync = hsync;
            prev_vsync = vsync;
            prev_de    = de;
        end
    endtask

    initial begin
        nrst = 1'b0;
        void'($urandom(97));
        rows[0] = '{PAT_ZERO, 2, V_TOTAL, H_ACTIVE * V_ACTIVE};
        rows[1] = '{PAT_ONE,  2, V_TOTAL, H_ACTIVE * V_ACTIVE};
        rows[2] = '{PAT_HASH, 3, V_TOTAL, H_ACTIVE * V_ACTIVE};
        rows[3] = '{PAT_RAND, 3, V_TOTAL, H_ACTIVE * V_ACTIVE};
        for (int r = 0; r < NUM_ROWS; r++) begin
            @(posedge clk);
            #1 nrst = 1'b0;
            sram_inst.fill(rows[r].pattern);   // new contents while in reset
            repeat (8) @(posedge clk);
            #1 nrst = 1'b1;
            @(negedge clk);
            check_value("de", 0, de);
            check_value("underrun", 0, underrun);
            check_value("hsync", 1, hsync);
            check_value("vsync", 1, vsync);
            prev_hsync = 1'b1;
            prev_vsync = 1'b1;
            prev_de    = 1'b0;
            hs_low = 0;
            vs_low = 0;
            x = 0;
            y = 0;
            watch_frame();   // first frame is blank, just sync up
            for (int f = 0; f < rows[r].frames; f++) begin
                watch_frame();
                check_value("hsync_pulses", rows[r].exp_hsync, hs_falls);
                check_value("de_pixels", rows[r].exp_de, de_cnt);
                check_value("sram_reads", FRAME_WORDS, rd_cnt);   // one whole frame fetched
            end
        end
        $display("NO ERRORS");
        $finish;
    end

endmodule
